/* hw/cpu16_pkg.sv */
package cpu16_pkg;

    localparam int INSTR_W = 16;

    // register file geometry
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS = 8;

    // instruction field positions
    localparam int OPC_HI = 15;
    localparam int OPC_LO = 11;
    localparam int RD_HI = 10;
    localparam int RD_LO = 8;
    localparam int RS_HI = 7;
    localparam int RS_LO = 5;
    localparam int RT_HI = 4; // register format only
    localparam int RT_LO = 2;
    localparam int IMM_HI = 4; // immediate format only
    localparam int IMM_LO = 0;
    localparam int IMM_W = IMM_HI - IMM_LO + 1;

    // unlisted codes decode as a nop
    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        OP_HALT = 5'd1,
        OP_ADD  = 5'd2,
        OP_SUB  = 5'd3,
        OP_AND  = 5'd4,
        OP_XOR  = 5'd5,
        OP_ADDI = 5'd6,
        OP_SLT  = 5'd7,
        OP_SEQ  = 5'd8
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_XOR = 3'd3,
        ALU_SLT = 3'd4, // set ops give 1 or 0
        ALU_SEQ = 3'd5
    } alu_op_e;

endpackage

/* hw/reg_file.sv */
module reg_file
    import cpu16_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_IDX_W-1:0] rd_idx_a,
    input  logic [REG_IDX_W-1:0] rd_idx_b,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]    wr_data,
    output logic [DATA_W-1:0]    rd_data_a,
    output logic [DATA_W-1:0]    rd_data_b
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // async reads, forwarding covers the write in flight
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* hw/inst_decode.sv */
module inst_decode
    import cpu16_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic                 instr_valid,
    input  logic [INSTR_W-1:0]   instr,
    input  logic                 take,
    input  logic                 ex_wr_en,
    input  logic [REG_IDX_W-1:0] ex_wr_reg,
    input  logic [DATA_W-1:0]    ex_result,
    input  logic [DATA_W-1:0]    rf_data_a,
    input  logic [DATA_W-1:0]    rf_data_b,
    output logic [REG_IDX_W-1:0] rf_idx_a,
    output logic [REG_IDX_W-1:0] rf_idx_b,
    output logic                 dec_valid,
    output logic                 dec_wr_en,
    output logic [REG_IDX_W-1:0] dec_wr_reg,
    output alu_op_e              dec_alu_op,
    output logic                 dec_is_halt,
    output logic [DATA_W-1:0]    dec_op_a,
    output logic [DATA_W-1:0]    dec_op_b
);

    opcode_e           opcode;
    logic              use_imm;
    logic              is_nop;
    logic [IMM_W-1:0]  imm;
    logic [DATA_W-1:0] sext_imm;
    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;

    assign opcode = opcode_e'(instr[OPC_HI:OPC_LO]);
    assign rf_idx_a = instr[RS_HI:RS_LO];
    assign rf_idx_b = instr[RT_HI:RT_LO];
    assign dec_wr_reg = instr[RD_HI:RD_LO];

    assign imm = instr[IMM_HI:IMM_LO];
    assign sext_imm = {{(DATA_W - IMM_W){imm[IMM_W-1]}}, imm};

    always_comb begin
        dec_alu_op = ALU_ADD;
        dec_wr_en = 1'b0;
        dec_is_halt = 1'b0;
        use_imm = 1'b0;
        is_nop = 1'b0;
        case (opcode)
            OP_HALT: dec_is_halt = 1'b1;
            OP_ADD: dec_wr_en = 1'b1;
            OP_SUB: begin
                dec_alu_op = ALU_SUB;
                dec_wr_en = 1'b1;
            end
            OP_AND: begin
                dec_alu_op = ALU_AND;
                dec_wr_en = 1'b1;
            end
            OP_XOR: begin
                dec_alu_op = ALU_XOR;
                dec_wr_en = 1'b1;
            end
            OP_ADDI: begin
                use_imm = 1'b1;
                dec_wr_en = 1'b1;
            end
            OP_SLT: begin
                dec_alu_op = ALU_SLT;
                dec_wr_en = 1'b1;
            end
            OP_SEQ: begin
                dec_alu_op = ALU_SEQ;
                dec_wr_en = 1'b1;
            end
            default: is_nop = 1'b1; // OP_NOP and unused codes
        endcase
    end

    // ex forwarding on rs and rt
    assign src_a = (ex_wr_en && ex_wr_reg == rf_idx_a) ? ex_result : rf_data_a;
    assign src_b = (ex_wr_en && ex_wr_reg == rf_idx_b) ? ex_result : rf_data_b;

    assign dec_op_a = src_a;
    assign dec_op_b = use_imm ? sext_imm : src_b;

    assign dec_valid = take && instr_valid && !is_nop; // bubble otherwise

endmodule

/* hw/id_ex.sv */
module id_ex
    import cpu16_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_n, // low freezes the stage
    input  logic                 dec_valid,
    input  logic                 dec_wr_en,
    input  logic [REG_IDX_W-1:0] dec_wr_reg,
    input  alu_op_e              dec_alu_op,
    input  logic                 dec_is_halt,
    input  logic [DATA_W-1:0]    dec_op_a,
    input  logic [DATA_W-1:0]    dec_op_b,
    output logic                 ex_valid,
    output logic                 ex_wr_en,
    output logic [REG_IDX_W-1:0] ex_wr_reg,
    output alu_op_e              ex_alu_op,
    output logic                 ex_is_halt,
    output logic [DATA_W-1:0]    ex_op_a,
    output logic [DATA_W-1:0]    ex_op_b
);

    // control bits, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wr_en <= 1'b0;
            ex_is_halt <= 1'b0;
        end else if (stall_n) begin
            ex_valid <= dec_valid; // low here is a bubble
            ex_wr_en <= dec_wr_en;
            ex_is_halt <= dec_is_halt;
        end
    end

    // payload, only meaningful with ex_valid
    always_ff @(posedge clk) begin
        if (stall_n) begin
            ex_wr_reg <= dec_wr_reg;
            ex_alu_op <= dec_alu_op;
            ex_op_a <= dec_op_a;
            ex_op_b <= dec_op_b;
        end
    end

endmodule

/* hw/ex_stage.sv */
module ex_stage
    import cpu16_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_n,
    input  logic                 ex_valid,
    input  logic                 ex_wr_en,
    input  logic [REG_IDX_W-1:0] ex_wr_reg,
    input  alu_op_e              ex_alu_op,
    input  logic                 ex_is_halt,
    input  logic [DATA_W-1:0]    ex_op_a,
    input  logic [DATA_W-1:0]    ex_op_b,
    output logic                 rf_wr_en,
    output logic [DATA_W-1:0]    ex_result,
    output logic                 wb_valid,
    output logic [REG_IDX_W-1:0] wb_reg,
    output logic [DATA_W-1:0]    wb_data,
    output logic                 halted
);

    logic writes;

    assign writes = ex_valid && ex_wr_en;
    assign rf_wr_en = writes && stall_n; // write on the advancing edge

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: ex_result = ex_op_a + ex_op_b;
            ALU_SUB: ex_result = ex_op_a - ex_op_b;
            ALU_AND: ex_result = ex_op_a & ex_op_b;
            ALU_XOR: ex_result = ex_op_a ^ ex_op_b;
            ALU_SLT: begin
                ex_result = '0;
                ex_result[0] = $signed(ex_op_a) < $signed(ex_op_b);
            end
            ALU_SEQ: begin
                ex_result = '0;
                ex_result[0] = ex_op_a == ex_op_b;
            end
            default: ex_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            halted <= 1'b0;
        end else if (stall_n) begin
            wb_valid <= writes; // halt gives no result
            if (ex_valid && ex_is_halt) begin
                halted <= 1'b1; // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stall_n) begin
            wb_reg <= ex_wr_reg;
            wb_data <= ex_result;
        end
    end

endmodule

/* hw/core_slice.sv */
module core_slice
    import cpu16_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  logic [INSTR_W-1:0]   instr,
    input  logic                 stall_n,
    output logic                 ready,
    output logic                 wb_valid,
    output logic [REG_IDX_W-1:0] wb_reg,
    output logic [DATA_W-1:0]    wb_data,
    output logic                 halted
);

    logic                 take;
    logic [REG_IDX_W-1:0] rf_idx_a;
    logic [REG_IDX_W-1:0] rf_idx_b;
    logic [DATA_W-1:0]    rf_data_a;
    logic [DATA_W-1:0]    rf_data_b;
    logic                 dec_valid;
    logic                 dec_wr_en;
    logic [REG_IDX_W-1:0] dec_wr_reg;
    alu_op_e              dec_alu_op;
    logic                 dec_is_halt;
    logic [DATA_W-1:0]    dec_op_a;
    logic [DATA_W-1:0]    dec_op_b;
    logic                 ex_valid;
    logic                 ex_wr_en;
    logic [REG_IDX_W-1:0] ex_wr_reg;
    alu_op_e              ex_alu_op;
    logic                 ex_is_halt;
    logic [DATA_W-1:0]    ex_op_a;
    logic [DATA_W-1:0]    ex_op_b;
    logic                 rf_wr_en;
    logic [DATA_W-1:0]    ex_result;

    assign ready = stall_n && !halted;
    assign take = instr_valid && ready;

    reg_file #(.DATA_W(DATA_W)) reg_file_i (
        .clk(clk), .rst(rst),
        .rd_idx_a(rf_idx_a), .rd_idx_b(rf_idx_b),
        .wr_en(rf_wr_en), .wr_idx(ex_wr_reg), .wr_data(ex_result),
        .rd_data_a(rf_data_a), .rd_data_b(rf_data_b)
    );

    inst_decode #(.DATA_W(DATA_W)) inst_decode_i (
        .instr_valid(instr_valid), .instr(instr), .take(take),
        .ex_wr_en(rf_wr_en), .ex_wr_reg(ex_wr_reg), .ex_result(ex_result), // fwd source
        .rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
        .rf_idx_a(rf_idx_a), .rf_idx_b(rf_idx_b),
        .dec_valid(dec_valid), .dec_wr_en(dec_wr_en), .dec_wr_reg(dec_wr_reg),
        .dec_alu_op(dec_alu_op), .dec_is_halt(dec_is_halt),
        .dec_op_a(dec_op_a), .dec_op_b(dec_op_b)
    );

    id_ex #(.DATA_W(DATA_W)) id_ex_i (
        .clk(clk), .rst(rst), .stall_n(stall_n),
        .dec_valid(dec_valid), .dec_wr_en(dec_wr_en), .dec_wr_reg(dec_wr_reg),
        .dec_alu_op(dec_alu_op), .dec_is_halt(dec_is_halt),
        .dec_op_a(dec_op_a), .dec_op_b(dec_op_b),
        .ex_valid(ex_valid), .ex_wr_en(ex_wr_en), .ex_wr_reg(ex_wr_reg),
        .ex_alu_op(ex_alu_op), .ex_is_halt(ex_is_halt),
        .ex_op_a(ex_op_a), .ex_op_b(ex_op_b)
    );

    ex_stage #(.DATA_W(DATA_W)) ex_stage_i (
        .clk(clk), .rst(rst), .stall_n(stall_n),
        .ex_valid(ex_valid), .ex_wr_en(ex_wr_en), .ex_wr_reg(ex_wr_reg),
        .ex_alu_op(ex_alu_op), .ex_is_halt(ex_is_halt),
        .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
        .rf_wr_en(rf_wr_en), .ex_result(ex_result),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
    );

endmodule

/* verification/core_slice_assert.sv */
module core_slice_assert
    import cpu16_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 stall_n,
    input logic                 wb_valid,
    input logic [REG_IDX_W-1:0] wb_reg,
    input logic [DATA_W-1:0]    wb_data,
    input logic                 halted
);

    reset_state_a: assert property (@(posedge clk) rst |=> !wb_valid && !halted)
        else $error("wb_valid or halted set after reset");

    // downstream stall freezes the result register
    wb_valid_hold_a: assert property (@(posedge clk) disable iff (rst)
        !stall_n |=> $stable(wb_valid))
        else $error("wb_valid changed while stalled");

    wb_data_hold_a: assert property (@(posedge clk) disable iff (rst)
        !stall_n && wb_valid |=> $stable(wb_reg) && $stable(wb_data))
        else $error("wb_reg or wb_data changed while stalled");

    halted_sticky_a: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("halted dropped without reset");

endmodule

/* verification/core_slice_tb.sv */
module core_slice_tb
    import cpu16_pkg::*;
();

    localparam int DATA_W = 16;
    localparam int CLK_PERIOD = 10;
    localparam int TEST_INSTRS = 157;
    localparam opcode_e ALU_OPS [7] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SLT, OP_SEQ, OP_ADDI};

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    logic [INSTR_W-1:0]   instr;
    logic                 stall_n;
    logic                 ready;
    logic                 wb_valid;
    logic [REG_IDX_W-1:0] wb_reg;
    logic [DATA_W-1:0]    wb_data;
    logic                 halted;

    logic [31:0]          lfsr;
    logic                 stall_on;
    logic                 taken = 1'b0; // set by the compare process
    logic                 halted_exp = 1'b0;
    logic                 halt_in_ex = 1'b0;
    string                test_name = "reset";
    logic [DATA_W-1:0]    model_regs [NUM_REGS] = '{default: '0};
    logic [REG_IDX_W-1:0] exp_reg_q [$];
    logic [DATA_W-1:0]    exp_data_q [$];

    core_slice #(.DATA_W(DATA_W)) dut_i (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .stall_n(stall_n),
        .ready(ready), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
    );

    bind core_slice core_slice_assert #(.DATA_W(DATA_W)) assert_i (
        .clk(clk), .rst(rst), .stall_n(stall_n), .wb_valid(wb_valid),
        .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_reg(input string what, input logic [REG_IDX_W-1:0] exp, act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input string what, input logic [DATA_W-1:0] exp, act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %0b, actual %0b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1; // galois step
        end
        return r;
    endfunction

    // n_ops of 6 keeps to register format and 7 adds addi
    function automatic logic [INSTR_W-1:0] random_instr(input int n_ops);
        opcode_e op;
        logic [31:0] r;
        op = ALU_OPS[int'(rand_bits(3)) % n_ops];
        r = rand_bits(11);
        return {op, r[10:0]};
    endfunction

    // model of one instruction against model_regs
    function automatic logic ref_exec(input logic [INSTR_W-1:0] word,
                                      output logic [DATA_W-1:0] value);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        a = model_regs[word[7:5]];
        b = model_regs[word[4:2]];
        value = '0;
        ref_exec = 1'b1;
        case (word[15:11])
            OP_ADD: value = a + b;
            OP_SUB: value = a - b;
            OP_AND: value = a & b;
            OP_XOR: value = a ^ b;
            OP_ADDI: value = a + {{(DATA_W - 5){word[4]}}, word[4:0]};
            OP_SLT: value[0] = $signed(a) < $signed(b);
            OP_SEQ: value[0] = a == b;
            default: ref_exec = 1'b0; // nop, halt and unused codes
        endcase
    endfunction

    always @(posedge clk) begin
        logic [DATA_W-1:0] value;
        logic accepted;
        logic writes;
        if (!rst) begin
            check_flag("ready", stall_n && !halted_exp, ready);
            check_flag("halted", halted_exp, halted);
            if (wb_valid && stall_n) begin
                if (exp_reg_q.size() == 0) begin
                    $display("[%s] result for r%0d appeared with none outstanding",
                             test_name, wb_reg);
                    abort_run();
                end else begin
                    check_reg("wb_reg", exp_reg_q.pop_front(), wb_reg);
                    check_data("wb_data", exp_data_q.pop_front(), wb_data);
                end
            end
            accepted = instr_valid && stall_n && !halted_exp;
            writes = ref_exec(instr, value);
            if (accepted && writes) begin
                exp_reg_q.push_back(instr[10:8]);
                exp_data_q.push_back(value);
                model_regs[instr[10:8]] = value;
            end
            if (stall_n) begin
                halted_exp = halted_exp || halt_in_ex; // halt leaving id/ex
                halt_in_ex = accepted && instr[15:11] == OP_HALT;
            end
            taken = accepted;
        end
    end

    // cycles 0 holds the word until it is taken
    task automatic drive(input logic [INSTR_W-1:0] word, input logic valid, input int cycles);
        instr = word;
        instr_valid = valid;
        do begin
            stall_n = !stall_on || rand_bits(2) != 0; // about a quarter stalled
            @(negedge clk);
            cycles--;
        end while (cycles > 0 || (cycles < 0 && !taken));
    endtask

    initial begin
        #(TEST_INSTRS * 40 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        logic [INSTR_W-1:0] word;
        logic [REG_IDX_W-1:0] rd_prev;
        logic [4:0] code;
        lfsr = 32'hb39981ac;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        stall_n = 1'b1;
        stall_on = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        test_name = "addi";
        drive({OP_ADDI, 3'd1, 3'd0, 5'h10}, 1'b1, 0); // most negative imm
        drive({OP_ADDI, 3'd2, 3'd0, 5'h0f}, 1'b1, 0);
        repeat (16) begin
            word = random_instr(7);
            word[15:11] = OP_ADDI;
            drive(word, 1'b1, 0);
        end
        test_name = "reg_ops";
        repeat (40) drive(random_instr(6), 1'b1, 0);
        test_name = "forwarding";
        repeat (20) begin
            rd_prev = word[10:8];
            word = random_instr(7);
            word[7:5] = rd_prev;
            if (rand_bits(1) != 0) word[4:2] = rd_prev;
            drive(word, 1'b1, 0);
        end
        test_name = "stall";
        stall_on = 1'b1;
        repeat (40) drive(random_instr(7), 1'b1, 0);
        stall_on = 1'b0;
        test_name = "nop_gaps";
        repeat (12) begin
            word = random_instr(7);
            code = 5'(rand_bits(5));
            word[15:11] = (code < 5'd9) ? 5'd0 : code;
            drive(word, 1'b1, 0);
            drive(random_instr(7), 1'b0, 1 + int'(rand_bits(2)));
            drive(random_instr(7), 1'b1, 0);
        end
        test_name = "halt";
        drive({OP_HALT, 11'd0}, 1'b1, 0);
        drive(random_instr(7), 1'b1, 0); // slips in behind the halt
        drive(random_instr(7), 1'b1, 8);
        check_flag("halted after halt", 1'b1, halted);
        check_flag("ready after halt", 1'b0, ready);
        while (exp_reg_q.size() != 0) drive(random_instr(7), 1'b0, 1);
        drive(random_instr(7), 1'b0, 8);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* flist.f */
hw/cpu16_pkg.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/id_ex.sv
hw/ex_stage.sv
hw/core_slice.sv
verification/core_slice_assert.sv
verification/core_slice_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module core_slice_tb -Mdir obj_dir -f flist.f
./obj_dir/Vcore_slice_tb
